// File: div_unit.f
+incdir+rtl
+incdir+tests
rtl/div_op_pkg.sv
rtl/div_ctrl_pkg.sv
rtl/clz.sv
rtl/div_decode.sv
rtl/div_core.sv
rtl/div_result.sv
rtl/div_unit.sv
tests/div_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the divide unit testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f div_unit.f --top-module div_unit_tb \
    -Mdir obj_dir -o div_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/div_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "=== PASS ==="; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

// File: tests/div_vectors.svh
// =========================================================================
// directed divide vectors
// named requests with their expected results, one row per operation.
// =========================================================================

`ifndef DIV_VECTORS_SVH
`define DIV_VECTORS_SVH

// columns: name, op, rs1, rs2, expected result.
task automatic load_vectors;
    // unsigned quotient and remainder.
    add_vector("divu_basic",     op_divu, 32'h00000064, 32'h00000007, 32'h0000000e);
    add_vector("remu_basic",     op_remu, 32'h00000064, 32'h00000007, 32'h00000002);
    add_vector("divu_small",     op_divu, 32'h00000005, 32'h00000009, 32'h00000000);
    add_vector("remu_small",     op_remu, 32'h00000005, 32'h00000009, 32'h00000005);
    add_vector("divu_equal",     op_divu, 32'h12345678, 32'h12345678, 32'h00000001);
    add_vector("remu_equal",     op_remu, 32'h12345678, 32'h12345678, 32'h00000000);
    add_vector("divu_by_one",    op_divu, 32'hdeadbeef, 32'h00000001, 32'hdeadbeef);
    add_vector("remu_by_one",    op_remu, 32'hdeadbeef, 32'h00000001, 32'h00000000);
    add_vector("divu_all_ones",  op_divu, 32'hffffffff, 32'hffffffff, 32'h00000001);
    add_vector("remu_all_ones",  op_remu, 32'hffffffff, 32'hffffffff, 32'h00000000);
    add_vector("divu_big",       op_divu, 32'hffffffff, 32'h00000002, 32'h7fffffff);
    add_vector("remu_big",       op_remu, 32'hffffffff, 32'h00000002, 32'h00000001);
    add_vector("divu_min_by_3",  op_divu, 32'h80000000, 32'h00000003, 32'h2aaaaaaa);
    add_vector("remu_min_by_3",  op_remu, 32'h80000000, 32'h00000003, 32'h00000002);
    // signed, all four sign combinations of 7 and 2.
    add_vector("div_pos_pos",    op_div,  32'h00000007, 32'h00000002, 32'h00000003);
    add_vector("rem_pos_pos",    op_rem,  32'h00000007, 32'h00000002, 32'h00000001);
    add_vector("div_neg_pos",    op_div,  32'hfffffff9, 32'h00000002, 32'hfffffffd);
    add_vector("rem_neg_pos",    op_rem,  32'hfffffff9, 32'h00000002, 32'hffffffff);
    add_vector("div_pos_neg",    op_div,  32'h00000007, 32'hfffffffe, 32'hfffffffd);
    add_vector("rem_pos_neg",    op_rem,  32'h00000007, 32'hfffffffe, 32'h00000001);
    add_vector("div_neg_neg",    op_div,  32'hfffffff9, 32'hfffffffe, 32'h00000003);
    add_vector("rem_neg_neg",    op_rem,  32'hfffffff9, 32'hfffffffe, 32'hffffffff);
    add_vector("div_neg_large",  op_div,  32'hffffff9c, 32'h00000007, 32'hfffffff2);
    add_vector("rem_neg_large",  op_rem,  32'hffffff9c, 32'h00000007, 32'hfffffffe);
    add_vector("div_min_by_2",   op_div,  32'h80000000, 32'h00000002, 32'hc0000000);
    // division by zero.
    add_vector("divu_zero",      op_divu, 32'h00001234, 32'h00000000, 32'hffffffff);
    add_vector("div_zero_neg",   op_div,  32'hfffffff9, 32'h00000000, 32'hffffffff);
    add_vector("div_zero_pos",   op_div,  32'h00000007, 32'h00000000, 32'hffffffff);
    add_vector("rem_zero",       op_rem,  32'hfffffff9, 32'h00000000, 32'hfffffff9);
    add_vector("remu_zero",      op_remu, 32'hdeadbeef, 32'h00000000, 32'hdeadbeef);
    // most negative value by -1.
    add_vector("div_overflow",   op_div,  32'h80000000, 32'hffffffff, 32'h80000000);
    add_vector("rem_overflow",   op_rem,  32'h80000000, 32'hffffffff, 32'h00000000);
endtask

`endif

// File: tests/div_unit_tb.sv
// =========================================================================
// divide unit testbench
// directed table and seeded random requests against a model of the
// RISC-V divide rules, with a busy check and a cycle timeout.
// =========================================================================

`timescale 1ns/1ns
`include "div_consts.svh"

module div_unit_tb;

    import div_op_pkg::*;

    localparam int XLEN       = `DIV_XLEN;
    localparam int NUM_RANDOM = 200;

    logic            clk = 1'b0;
    logic            rst;
    logic            start;
    div_op_t         op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            busy;
    logic            done;
    logic [XLEN-1:0] result;

    int seed        = 98775;
    int cycle_count = 0;
    int cycle_limit;

    // directed vector table, filled by load_vectors.
    string           vec_name[$];
    div_op_t         vec_op[$];
    logic [XLEN-1:0] vec_rs1[$];
    logic [XLEN-1:0] vec_rs2[$];
    logic [XLEN-1:0] vec_result[$];

    div_unit dut_i (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .rs1    (rs1),
        .rs2    (rs2),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #2 clk = ~clk;                                   // 4 ns period.

    task automatic add_vector(input string name, input div_op_t v_op,
                              input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                              input logic [XLEN-1:0] expected);
        vec_name.push_back(name);
        vec_op.push_back(v_op);
        vec_rs1.push_back(a);
        vec_rs2.push_back(b);
        vec_result.push_back(expected);
    endtask

    `include "div_vectors.svh"

    // RISC-V M-extension divide rules.
    function automatic logic [XLEN-1:0] model_result(input div_op_t m_op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] sq;
        logic signed [XLEN-1:0] sr;
        logic                   ovf;
        sa  = a;
        sb  = b;
        sq  = '0;
        sr  = '0;
        ovf = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);   // min / -1.
        if (b != '0 && !ovf) begin
            sq = sa / sb;                                   // toward zero.
            sr = sa % sb;                                   // dividend sign.
        end
        case (m_op)
            op_divu: model_result = (b == '0) ? '1 : a / b;
            op_remu: model_result = (b == '0) ? a : a % b;
            op_div:  model_result = (b == '0) ? '1 : (ovf ? a : sq);
            default: model_result = (b == '0) ? a : (ovf ? '0 : sr);
        endcase
    endfunction

    // returns right after the edge that samples done high.
    task automatic wait_done;
        do begin
            @(posedge clk);
        end while (done !== 1'b1);
    endtask

    task automatic check_result(input string name, input logic [XLEN-1:0] expected);
        assert (result === expected) else begin
            $display("FAILED %s expected %h actual %h", name, expected, result);
            $display("=== FAIL ===");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // called right after a rising edge, so requests run back to back.
    task automatic run_op(input string name, input div_op_t v_op,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                          input logic [XLEN-1:0] expected);
        start <= 1'b1;
        op    <= v_op;
        rs1   <= a;
        rs2   <= b;
        @(posedge clk);
        start <= 1'b0;                                      // one-cycle strobe.
        wait_done();
        check_result(name, expected);
    endtask

    // ========================================================================
    // timeout
    // ========================================================================

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the divide unit gave no result within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "simulation timed out");
        end
    end

    // ========================================================================
    // stimulus
    // ========================================================================

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pick;
        div_op_t         r_op;
        rst   <= 1'b1;
        start <= 1'b0;
        op    <= op_divu;
        rs1   <= '0;
        rs2   <= '0;
        load_vectors();
        cycle_limit = (vec_name.size() + NUM_RANDOM) * (XLEN + 8);

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (busy === 1'b0 && done === 1'b0) else begin
            $display("busy or done is not low after reset");
            $display("=== FAIL ===");
            $fatal(1, "reset state wrong");
        end

        for (int i = 0; i < vec_name.size(); i++) begin
            run_op(vec_name[i], vec_op[i], vec_rs1[i], vec_rs2[i], vec_result[i]);
        end

        // second start while busy must be dropped.
        start <= 1'b1;
        op    <= op_divu;
        rs1   <= 32'hffffffff;
        rs2   <= 32'h00000003;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        assert (busy === 1'b1) else begin
            $display("busy is not high after an accepted start");
            $display("=== FAIL ===");
            $fatal(1, "busy flag wrong");
        end
        start <= 1'b1;                                      // ignored request.
        op    <= op_remu;
        rs1   <= 32'h00000064;
        rs2   <= 32'h00000007;
        @(posedge clk);
        start <= 1'b0;
        wait_done();
        check_result("busy_ignore", 32'h55555555);
        @(posedge clk);
        assert (busy === 1'b0 && done === 1'b0) else begin
            $display("a start given while busy was accepted");
            $display("=== FAIL ===");
            $fatal(1, "busy gating wrong");
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            a    = $random(seed);
            b    = $random(seed);
            pick = $random(seed);
            r_op = div_op_t'(pick[9:8]);
            if (pick[2:0] == 3'd0) begin
                b = '0;                                     // zero divisor now and then.
            end else begin
                b = b >> pick[7:3];                         // spread divisor sizes.
            end
            run_op($sformatf("random_%0d", i), r_op, a, b, model_result(r_op, a, b));
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: rtl/div_unit.sv
// =========================================================================
// integer divide unit
// div, divu, rem and remu on 32-bit operands, one operation at a time.
// =========================================================================

`timescale 1ns/1ns
`include "div_consts.svh"

module div_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  div_op_pkg::div_op_t  op,
    input  logic [`DIV_XLEN-1:0] rs1,
    input  logic [`DIV_XLEN-1:0] rs2,
    output logic                 busy,
    output logic                 done,
    output logic [`DIV_XLEN-1:0] result
);

    localparam int XLEN = `DIV_XLEN;

    logic            accept;
    logic            core_start;
    logic            core_done;
    logic [XLEN-1:0] dividend_mag;
    logic [XLEN-1:0] divisor_mag;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;
    logic            divisor_is_zero;
    logic            want_rem;
    logic            quot_neg;
    logic            rem_neg;

    assign accept = start && !busy;                         // starts while busy are dropped.

    // set by an accepted start, cleared after the done cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    div_decode decode_i (
        .clk          (clk),
        .rst          (rst),
        .start        (accept),
        .op           (op),
        .rs1          (rs1),
        .rs2          (rs2),
        .core_start   (core_start),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .want_rem     (want_rem),
        .quot_neg     (quot_neg),
        .rem_neg      (rem_neg)
    );

    div_core core_i (
        .clk             (clk),
        .rst             (rst),
        .start           (core_start),
        .dividend        (dividend_mag),
        .divisor         (divisor_mag),
        .quotient        (quotient),
        .remainder       (remainder),
        .divisor_is_zero (divisor_is_zero),
        .done            (core_done)
    );

    div_result result_i (
        .clk             (clk),
        .rst             (rst),
        .core_done       (core_done),
        .quotient        (quotient),
        .remainder       (remainder),
        .divisor_is_zero (divisor_is_zero),
        .want_rem        (want_rem),
        .quot_neg        (quot_neg),
        .rem_neg         (rem_neg),
        .done            (done),
        .result          (result)
    );

endmodule

// File: rtl/div_result.sv
// =========================================================================
// divide result
// selects quotient or remainder, restores the sign, keeps the all-ones
// quotient of a zero divisor and registers the final value.
// =========================================================================

`timescale 1ns/1ns
`include "div_consts.svh"

module div_result (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 core_done,
    input  logic [`DIV_XLEN-1:0] quotient,
    input  logic [`DIV_XLEN-1:0] remainder,
    input  logic                 divisor_is_zero,
    input  logic                 want_rem,
    input  logic                 quot_neg,
    input  logic                 rem_neg,
    output logic                 done,
    output logic [`DIV_XLEN-1:0] result
);

    localparam int XLEN = `DIV_XLEN;

    logic            flip_quot;
    logic [XLEN-1:0] quot_signed;
    logic [XLEN-1:0] rem_signed;
    logic [XLEN-1:0] result_next;

    // =========================================================================
    // sign restore
    // =========================================================================

    // x / 0 is all ones for every op, so the sign is left alone then.
    assign flip_quot   = quot_neg && !divisor_is_zero;
    assign quot_signed = flip_quot ? -quotient : quotient;

    // remainder follows the dividend, which also returns rs1 for x % 0.
    assign rem_signed  = rem_neg ? -remainder : remainder;

    assign result_next = want_rem ? rem_signed : quot_signed;

    // =========================================================================
    // output registers
    // =========================================================================

    // held until the next done.
    always_ff @(posedge clk) begin
        if (core_done) begin
            result <= result_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= core_done;                              // one-cycle pulse.
        end
    end

endmodule

// File: rtl/div_core.sv
// =========================================================================
// quick unsigned divider
// aligns the divisor to the remainder with leading-zero counts and retires
// one or two quotient bits per cycle. a zero divisor finishes at once.
// =========================================================================

`timescale 1ns/1ns
`include "div_consts.svh"

module div_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [`DIV_XLEN-1:0] dividend,
    input  logic [`DIV_XLEN-1:0] divisor,
    output logic [`DIV_XLEN-1:0] quotient,
    output logic [`DIV_XLEN-1:0] remainder,
    output logic                 divisor_is_zero,
    output logic                 done
);

    import div_ctrl_pkg::*;

    localparam int XLEN  = `DIV_XLEN;
    localparam int CLZ_W = `DIV_CLZ_W;

    div_state_t      state;
    logic            div_zero;
    logic            zero_r;
    logic            terminate;
    logic            step;
    logic [XLEN-1:0] divisor_r;

    logic [CLZ_W-1:0] rem_clz;
    logic [CLZ_W-1:0] div_clz;
    logic [CLZ_W-1:0] div_clz_r;
    logic [CLZ_W-1:0] clz_delta;

    logic [XLEN-1:0] shifted_b;
    logic [XLEN-1:0] b1;
    logic [XLEN-1:0] b2;
    logic [XLEN:0]   a0;
    logic [XLEN:0]   a1;
    logic [XLEN-1:0] a2;
    logic [XLEN-1:0] q_bit1;
    logic [XLEN-1:0] q_bit2;
    logic [XLEN-1:0] new_q_bit;
    logic [XLEN-1:0] new_r;

    clz clz_rem_i (.in(remainder), .count(rem_clz));
    clz clz_div_i (.in(divisor),   .count(div_clz));

    // all-ones count with a clear lsb only happens for a zero word.
    assign div_zero = (div_clz == '1) && !divisor[0];

    // divisor normalised to bit XLEN-1, captured with the request.
    always_ff @(posedge clk) begin
        if (start) begin
            div_clz_r <= div_clz;
            shifted_b <= divisor << div_clz;
            divisor_r <= divisor;
            zero_r    <= div_zero;
        end
    end

    // =========================================================================
    // iteration step
    // =========================================================================

    assign clz_delta = div_clz_r - rem_clz;                 // weight of the top quotient bit.

    always_comb begin
        q_bit1            = '0;
        q_bit1[clz_delta] = 1'b1;
    end
    assign q_bit2 = {1'b0, q_bit1[XLEN-1:1]};               // next lower bit.

    assign b1 = shifted_b >> rem_clz;                       // msb aligned to the remainder.
    assign b2 = {1'b0, b1[XLEN-1:1]};                       // half of b1.
    assign a1 = {1'b0, remainder} - {1'b0, b1};
    assign a2 = remainder - b2;                             // never borrows.
    assign a0 = {1'b0, remainder} - ({1'b0, b1} + {1'b0, b2});

    // pick the largest subtraction that does not borrow.
    always_comb begin
        if (a1[XLEN]) begin
            new_q_bit = q_bit2;
            new_r     = a2;
        end else if (a0[XLEN] || clz_delta == '0) begin
            new_q_bit = q_bit1;
            new_r     = a1[XLEN-1:0];
        end else begin
            new_q_bit = q_bit1 | q_bit2;                    // two bits this cycle.
            new_r     = a0[XLEN-1:0];
        end
    end

    assign terminate = (remainder < divisor_r);
    assign step      = (state == st_run) && !terminate;

    // =========================================================================
    // control
    // =========================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else if (start) begin
            state <= div_zero ? st_done : st_run;           // zero divisor skips the loop.
        end else begin
            case (state)
                st_run: begin
                    if (terminate) begin
                        state <= st_done;
                    end
                end
                st_done: state <= st_idle;                  // done lasts one cycle.
                default: state <= st_idle;
            endcase
        end
    end

    // quotient and remainder hold after done.
    always_ff @(posedge clk) begin
        if (start) begin
            quotient  <= div_zero ? '1 : '0;
            remainder <= dividend;
        end else if (step) begin
            quotient  <= quotient | new_q_bit;
            remainder <= new_r;
        end
    end

    assign done            = (state == st_done);
    assign divisor_is_zero = zero_r;

endmodule

// File: rtl/div_decode.sv
// =========================================================================
// divide decode
// captures an accepted request, splits signed operands into magnitude and
// sign, and issues the core start one cycle later.
// =========================================================================

`timescale 1ns/1ns
`include "div_consts.svh"

module div_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  div_op_pkg::div_op_t    op,
    input  logic [`DIV_XLEN-1:0]   rs1,
    input  logic [`DIV_XLEN-1:0]   rs2,
    output logic                   core_start,
    output logic [`DIV_XLEN-1:0]   dividend_mag,
    output logic [`DIV_XLEN-1:0]   divisor_mag,
    output logic                   want_rem,
    output logic                   quot_neg,
    output logic                   rem_neg
);

    import div_op_pkg::*;

    localparam int XLEN = `DIV_XLEN;

    logic            is_signed;
    div_sign_t       rs1_sign;
    div_sign_t       rs2_sign;
    logic [XLEN-1:0] rs1_mag;
    logic [XLEN-1:0] rs2_mag;

    // =========================================================================
    // sign split
    // =========================================================================

    assign is_signed = (op == op_div) || (op == op_rem);         // div and rem.

    assign rs1_sign = (is_signed && rs1[XLEN-1]) ? sgn_neg : sgn_pos;
    assign rs2_sign = (is_signed && rs2[XLEN-1]) ? sgn_neg : sgn_pos;

    assign rs1_mag = (rs1_sign == sgn_neg) ? -rs1 : rs1;          // two's complement.
    assign rs2_mag = (rs2_sign == sgn_neg) ? -rs2 : rs2;          // min value maps to 2**31.

    // =========================================================================
    // request registers
    // =========================================================================

    // held until the next accepted start.
    always_ff @(posedge clk) begin
        if (start) begin
            dividend_mag <= rs1_mag;
            divisor_mag  <= rs2_mag;
            want_rem     <= (op == op_rem) || (op == op_remu);   // remainder wanted.
            quot_neg     <= (rs1_sign != rs2_sign);              // signs differ.
            rem_neg      <= (rs1_sign == sgn_neg);               // follows the dividend.
        end
    end

    // core start trails the accepted request by one cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            core_start <= 1'b0;
        end else begin
            core_start <= start;
        end
    end

endmodule

// File: rtl/clz.sv
// =========================================================================
// count leading zeros
// priority encoder giving the number of leading zeros of a word.
// a zero word gives the all-ones count.
// =========================================================================

`timescale 1ns/1ns
`include "div_consts.svh"

module clz (
    input  logic [`DIV_XLEN-1:0]  in,
    output logic [`DIV_CLZ_W-1:0] count
);

    localparam int XLEN  = `DIV_XLEN;
    localparam int CLZ_W = `DIV_CLZ_W;

    // scan upward so the highest set bit is the last one written.
    always_comb begin
        count = '1;                                   // zero input result.
        for (int i = 0; i < XLEN; i++) begin
            if (in[i]) begin
                count = CLZ_W'(XLEN - 1 - i);         // zeros above bit i.
            end
        end
    end

endmodule

// File: rtl/div_ctrl_pkg.sv
// =========================================================================
// divider control
// state encoding of the iterative divider core.
// =========================================================================

package div_ctrl_pkg;

    // core sequencing.
    typedef enum logic [1:0] {
        st_idle = 2'b00,  // waiting for a start pulse.
        st_run  = 2'b01,  // retiring quotient bits.
        st_done = 2'b10   // quotient and remainder final, done high.
    } div_state_t;

endpackage

// File: rtl/div_op_pkg.sv
// =========================================================================
// divide opcodes
// the four M-extension divide operations and the operand sign type used
// when a request is split into magnitude and sign.
// =========================================================================

package div_op_pkg;

    // opcode of a divide request.
    typedef enum logic [1:0] {
        op_div  = 2'b00,  // signed quotient.
        op_divu = 2'b01,  // unsigned quotient.
        op_rem  = 2'b10,  // signed remainder.
        op_remu = 2'b11   // unsigned remainder.
    } div_op_t;

    // sign of one operand after decode.
    typedef enum logic {
        sgn_pos = 1'b0,   // zero or positive, or any unsigned operand.
        sgn_neg = 1'b1    // negative signed operand.
    } div_sign_t;

endpackage

// File: rtl/div_consts.svh
// =========================================================================
// divide unit constants
// operand width and the width of a leading-zero count.
// =========================================================================

`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// operand and result width.
`define DIV_XLEN 32

// width of a leading-zero count over DIV_XLEN bits.
`define DIV_CLZ_W 5

`endif
